/* source/readout_geom_pkg.sv */
package readout_geom_pkg;

    // ----------------------------------------
    // line geometry
    // ----------------------------------------

    // readout chip line buffers, walked in order
    localparam int NUM_BANKS       = 12;
    // beats served from one bank per line
    localparam int PIXELS_PER_BANK = 128;
    // fixed line length, all banks back to back
    localparam int LINE_BEATS      = NUM_BANKS * PIXELS_PER_BANK;
    localparam int PIXEL_W         = 24;

    // ----------------------------------------
    // data types
    // ----------------------------------------

    typedef logic [PIXEL_W-1:0]   pixel_t;
    // one bit per bank, at most one set
    typedef logic [NUM_BANKS-1:0] bank_onehot_t;
    // pixel or line position
    typedef logic [15:0]          pos_t;
    // line count vs image height
    typedef logic [11:0]          line_cnt_t;

endpackage

/* source/readout_ctrl_pkg.sv */
package readout_ctrl_pkg;

    // ----------------------------------------
    // sync timing
    // ----------------------------------------

    // input flops on read_index
    localparam int SYNC_STAGES = 2;
    // restart to frame trigger
    localparam int FRAME_DELAY = 3;
    // hsync hold after the final bank
    localparam int HSYNC_HOLD  = 5;
    // vsync hold after the final line
    localparam int VSYNC_HOLD  = 15;
    // beat to output register
    localparam int OUT_DELAY   = 3;
    // first beat to frame_start
    localparam int START_DELAY = 12;

    // ----------------------------------------
    // state encodings
    // ----------------------------------------

    typedef enum logic [1:0] {FRAME_IDLE, FRAME_ACTIVE, FRAME_HOLD} frame_state_e;
    typedef enum logic [1:0] {LINE_IDLE, LINE_ACTIVE, LINE_HOLD} line_state_e;

endpackage

/* source/frame_sync_gen.sv */
`timescale 1ns/100ps

module frame_sync_gen
    import readout_geom_pkg::*;
    import readout_ctrl_pkg::*;
(
    input  logic      eim_clk,
    input  logic      eim_rst,
    input  logic      read_index,
    input  logic      aed_read_index,
    input  logic      hsync,
    input  line_cnt_t image_height,
    output logic      restart,
    output logic      frame_trigger,
    output logic      frame_reset,
    output logic      lines_done
);

    typedef logic [$clog2(VSYNC_HOLD + 1)-1:0] vhold_cnt_t;

    logic [SYNC_STAGES-1:0] ri_sync;
    logic [FRAME_DELAY-1:0] restart_dly;
    logic                   hsync_q;
    logic                   hsync_fall;
    line_cnt_t              line_cnt;
    vhold_cnt_t             hold_cnt;
    frame_state_e           frame_state;

    // ----------------------------------------
    // read index sync, restart, trigger
    // ----------------------------------------

    // rise on the synced level, blocked during auto-exposure reads
    assign restart = ri_sync[SYNC_STAGES-2] && !ri_sync[SYNC_STAGES-1] && !aed_read_index;
    assign frame_trigger = restart_dly[FRAME_DELAY-1];

    always_ff @(posedge eim_clk or negedge eim_rst) begin
        if (!eim_rst) begin
            ri_sync     <= '0;
            restart_dly <= '0;
            frame_reset <= 1'b0;
        end else begin
            ri_sync     <= {ri_sync[SYNC_STAGES-2:0], read_index};
            restart_dly <= {restart_dly[FRAME_DELAY-2:0], restart};
            // one cycle behind the trigger
            frame_reset <= frame_trigger;
        end
    end

    // ----------------------------------------
    // line count
    // ----------------------------------------

    assign hsync_fall = hsync_q && !hsync;

    always_ff @(posedge eim_clk or negedge eim_rst) begin
        if (!eim_rst) begin
            hsync_q    <= 1'b0;
            line_cnt   <= '0;
            lines_done <= 1'b0;
        end else begin
            hsync_q    <= hsync;
            lines_done <= 1'b0;
            if (restart || lines_done) begin
                line_cnt <= '0;
            end else if (hsync_fall && frame_state == FRAME_ACTIVE) begin
                line_cnt   <= line_cnt + line_cnt_t'(1);
                // final line of the frame
                lines_done <= (line_cnt == image_height - line_cnt_t'(1));
            end
        end
    end

    // vsync level is any state but idle
    always_ff @(posedge eim_clk or negedge eim_rst) begin
        if (!eim_rst) begin
            frame_state <= FRAME_IDLE;
            hold_cnt    <= '0;
        end else if (restart) begin
            frame_state <= FRAME_IDLE;
            hold_cnt    <= '0;
        end else begin
            case (frame_state)
                FRAME_IDLE: begin
                    if (frame_trigger) begin
                        frame_state <= FRAME_ACTIVE;
                    end
                end
                FRAME_ACTIVE: begin
                    if (lines_done) begin
                        frame_state <= FRAME_HOLD;
                        hold_cnt    <= '0;
                    end
                end
                FRAME_HOLD: begin
                    // keep vsync up past the last line
                    hold_cnt <= hold_cnt + vhold_cnt_t'(1);
                    if (hold_cnt == vhold_cnt_t'(VSYNC_HOLD - 1)) begin
                        frame_state <= FRAME_IDLE;
                    end
                end
                default: frame_state <= FRAME_IDLE;
            endcase
        end
    end

endmodule

/* source/line_sync_gen.sv */
`timescale 1ns/100ps

module line_sync_gen
    import readout_ctrl_pkg::*;
(
    input  logic eim_clk,
    input  logic eim_rst,
    input  logic restart,
    input  logic line_start,
    input  logic bank_final,
    input  logic read_index,
    output logic hsync,
    output logic line_resume
);

    typedef logic [$clog2(HSYNC_HOLD + 1)-1:0] hhold_cnt_t;

    line_state_e line_state;
    hhold_cnt_t  hold_cnt;

    // high from line start through the hold
    assign hsync = (line_state != LINE_IDLE);

    always_ff @(posedge eim_clk or negedge eim_rst) begin
        if (!eim_rst) begin
            line_state  <= LINE_IDLE;
            hold_cnt    <= '0;
            line_resume <= 1'b0;
        end else if (restart) begin
            line_state  <= LINE_IDLE;
            hold_cnt    <= '0;
            line_resume <= 1'b0;
        end else begin
            case (line_state)
                LINE_IDLE: begin
                    if (line_start) begin
                        line_state <= LINE_ACTIVE;
                    end
                end
                LINE_ACTIVE: begin
                    // bank 11 done, start the hold
                    if (bank_final) begin
                        line_state <= LINE_HOLD;
                        hold_cnt   <= '0;
                    end
                end
                LINE_HOLD: begin
                    hold_cnt <= hold_cnt + hhold_cnt_t'(1);
                    if (hold_cnt == hhold_cnt_t'(HSYNC_HOLD - 1)) begin
                        line_state  <= LINE_IDLE;
                        // remember read index for the next line requests
                        line_resume <= read_index;
                    end
                end
                default: line_state <= LINE_IDLE;
            endcase
        end
    end

endmodule

/* source/pixel_counter.sv */
`timescale 1ns/100ps

module pixel_counter
    import readout_geom_pkg::*;
(
    input  logic eim_clk,
    input  logic eim_rst,
    input  logic restart,
    input  logic frame_trigger,
    input  logic lines_done,
    input  logic hsync,
    input  logic axis_tready,
    output logic beat_valid,
    output logic beat_last,
    output logic beat_first,
    output pos_t pixel_pos
);

    logic hsync_q;
    logic line_open;
    logic first_armed;
    pos_t line_pos;

    // offer only while the line window is open and the consumer is ready
    assign beat_valid = hsync && line_open && axis_tready;
    assign beat_last  = beat_valid && (pixel_pos == pos_t'(LINE_BEATS - 1));
    assign beat_first = beat_valid && first_armed && (pixel_pos == '0) && (line_pos == '0);

    always_ff @(posedge eim_clk or negedge eim_rst) begin
        if (!eim_rst) begin
            hsync_q     <= 1'b0;
            line_open   <= 1'b0;
            first_armed <= 1'b0;
            pixel_pos   <= '0;
            line_pos    <= '0;
        end else begin
            hsync_q <= hsync;
            if (restart) begin
                line_open   <= 1'b0;
                first_armed <= 1'b0;
                pixel_pos   <= '0;
                line_pos    <= '0;
            end else begin
                // window opens on hsync rise, shuts on last beat
                if (hsync && !hsync_q) begin
                    line_open <= 1'b1;
                end else if (beat_last) begin
                    line_open <= 1'b0;
                end
                // only a triggered frame gets a start mark
                if (frame_trigger) begin
                    first_armed <= 1'b1;
                end else if (beat_first) begin
                    first_armed <= 1'b0;
                end
                // stalls with tready low
                if (frame_trigger || lines_done) begin
                    pixel_pos <= '0;
                    line_pos  <= '0;
                end else if (beat_valid) begin
                    if (beat_last) begin
                        pixel_pos <= '0;
                        line_pos  <= line_pos + pos_t'(1);
                    end else begin
                        pixel_pos <= pixel_pos + pos_t'(1);
                    end
                end
            end
        end
    end

endmodule

/* source/bank_sequencer.sv */
`timescale 1ns/100ps

module bank_sequencer
    import readout_geom_pkg::*;
(
    input  logic         eim_clk,
    input  logic         eim_rst,
    input  logic         restart,
    input  logic         hsync,
    input  logic         line_resume,
    input  logic         read_index,
    input  logic         csi_done,
    input  logic         valid_read_mem,
    input  logic         beat_valid,
    input  pos_t         pixel_pos,
    output bank_onehot_t bank_sel,
    output logic         bank_final,
    output bank_onehot_t bank_read_req
);

    logic hsync_q;
    logic bank_end;

    // last accepted beat of the current bank
    assign bank_end = beat_valid && valid_read_mem &&
                      (pos_t'(pixel_pos % PIXELS_PER_BANK) == pos_t'(PIXELS_PER_BANK - 1));
    assign bank_final = bank_end && bank_sel[NUM_BANKS-1];

    // request gated by csi done, read index or the level held from last line end
    assign bank_read_req = (beat_valid && csi_done && (read_index || line_resume)) ?
                           bank_sel : '0;

    // ----------------------------------------
    // one-hot walk
    // ----------------------------------------

    always_ff @(posedge eim_clk or negedge eim_rst) begin
        if (!eim_rst) begin
            hsync_q  <= 1'b0;
            bank_sel <= '0;
        end else begin
            hsync_q <= hsync;
            if (restart) begin
                bank_sel <= '0;
            end else if (hsync && !hsync_q) begin
                // bank 0 on line start
                bank_sel <= bank_onehot_t'(1);
            end else if (bank_end) begin
                // bank 11 shifts out, leaving none selected
                bank_sel <= bank_sel << 1;
            end
        end
    end

endmodule

/* source/pixel_output_stage.sv */
`timescale 1ns/100ps

module pixel_output_stage
    import readout_geom_pkg::*;
    import readout_ctrl_pkg::*;
(
    input  logic         eim_clk,
    input  logic         eim_rst,
    input  logic         restart,
    input  logic         beat_valid,
    input  logic         beat_last,
    input  logic         beat_first,
    input  bank_onehot_t bank_sel,
    input  pixel_t       bank_data_a [NUM_BANKS],
    input  pixel_t       bank_data_b [NUM_BANKS],
    output logic         data_valid,
    output logic         axis_tlast,
    output pixel_t       data_out_a,
    output pixel_t       data_out_b,
    output logic         frame_start
);

    logic [OUT_DELAY-1:0]   valid_dly;
    logic [OUT_DELAY-1:0]   last_dly;
    bank_onehot_t           sel_dly [OUT_DELAY];
    logic [START_DELAY-1:0] start_dly;
    pixel_t                 mux_a;
    pixel_t                 mux_b;

    // selected bank pair, zero with no bank
    always_comb begin
        mux_a = '0;
        mux_b = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (sel_dly[OUT_DELAY-1][i]) begin
                mux_a = bank_data_a[i];
                mux_b = bank_data_b[i];
            end
        end
    end

    // ----------------------------------------
    // control pipeline
    // ----------------------------------------

    always_ff @(posedge eim_clk or negedge eim_rst) begin
        if (!eim_rst) begin
            valid_dly   <= '0;
            last_dly    <= '0;
            sel_dly     <= '{default: '0};
            start_dly   <= '0;
            data_valid  <= 1'b0;
            axis_tlast  <= 1'b0;
            frame_start <= 1'b0;
        end else if (restart) begin
            valid_dly   <= '0;
            last_dly    <= '0;
            sel_dly     <= '{default: '0};
            start_dly   <= '0;
            data_valid  <= 1'b0;
            axis_tlast  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            // runs every cycle, drains under back-pressure
            valid_dly  <= {valid_dly[OUT_DELAY-2:0], beat_valid};
            last_dly   <= {last_dly[OUT_DELAY-2:0], beat_last};
            sel_dly[0] <= bank_sel;
            for (int i = 1; i < OUT_DELAY; i++) begin
                sel_dly[i] <= sel_dly[i-1];
            end
            // longer delay on the frame start mark
            start_dly   <= {start_dly[START_DELAY-2:0], beat_first};
            data_valid  <= valid_dly[OUT_DELAY-1];
            axis_tlast  <= last_dly[OUT_DELAY-1];
            frame_start <= start_dly[START_DELAY-1];
        end
    end

    // data lines up with data_valid
    always_ff @(posedge eim_clk) begin
        data_out_a <= mux_a;
        data_out_b <= mux_b;
    end

endmodule

/* source/readout_mux_top.sv */
`timescale 1ns/100ps

module readout_mux_top
    import readout_geom_pkg::*;
(
    input  logic         eim_clk,
    input  logic         eim_rst,
    input  logic         read_index,
    input  logic         aed_read_index,
    input  logic         line_start,
    input  logic         csi_done,
    input  line_cnt_t    image_height,
    input  logic         valid_read_mem,
    input  logic         axis_tready,
    input  pixel_t       bank_data_a [NUM_BANKS],
    input  pixel_t       bank_data_b [NUM_BANKS],
    output logic         data_valid,
    output logic         axis_tlast,
    output pixel_t       data_out_a,
    output pixel_t       data_out_b,
    output logic         frame_start,
    output logic         frame_reset,
    output bank_onehot_t bank_read_req
);

    // frame control
    logic         restart;
    logic         frame_trigger;
    logic         lines_done;
    // line control
    logic         hsync;
    logic         line_resume;
    // beat stream
    logic         beat_valid;
    logic         beat_last;
    logic         beat_first;
    pos_t         pixel_pos;
    // bank walk
    bank_onehot_t bank_sel;
    logic         bank_final;

    frame_sync_gen u_frame_sync_gen (
        .eim_clk        (eim_clk),
        .eim_rst        (eim_rst),
        .read_index     (read_index),
        .aed_read_index (aed_read_index),
        .hsync          (hsync),
        .image_height   (image_height),
        .restart        (restart),
        .frame_trigger  (frame_trigger),
        .frame_reset    (frame_reset),
        .lines_done     (lines_done)
    );

    line_sync_gen u_line_sync_gen (
        .eim_clk     (eim_clk),
        .eim_rst     (eim_rst),
        .restart     (restart),
        .line_start  (line_start),
        .bank_final  (bank_final),
        .read_index  (read_index),
        .hsync       (hsync),
        .line_resume (line_resume)
    );

    pixel_counter u_pixel_counter (
        .eim_clk       (eim_clk),
        .eim_rst       (eim_rst),
        .restart       (restart),
        .frame_trigger (frame_trigger),
        .lines_done    (lines_done),
        .hsync         (hsync),
        .axis_tready   (axis_tready),
        .beat_valid    (beat_valid),
        .beat_last     (beat_last),
        .beat_first    (beat_first),
        .pixel_pos     (pixel_pos)
    );

    bank_sequencer u_bank_sequencer (
        .eim_clk        (eim_clk),
        .eim_rst        (eim_rst),
        .restart        (restart),
        .hsync          (hsync),
        .line_resume    (line_resume),
        .read_index     (read_index),
        .csi_done       (csi_done),
        .valid_read_mem (valid_read_mem),
        .beat_valid     (beat_valid),
        .pixel_pos      (pixel_pos),
        .bank_sel       (bank_sel),
        .bank_final     (bank_final),
        .bank_read_req  (bank_read_req)
    );

    pixel_output_stage u_pixel_output_stage (
        .eim_clk     (eim_clk),
        .eim_rst     (eim_rst),
        .restart     (restart),
        .beat_valid  (beat_valid),
        .beat_last   (beat_last),
        .beat_first  (beat_first),
        .bank_sel    (bank_sel),
        .bank_data_a (bank_data_a),
        .bank_data_b (bank_data_b),
        .data_valid  (data_valid),
        .axis_tlast  (axis_tlast),
        .data_out_a  (data_out_a),
        .data_out_b  (data_out_b),
        .frame_start (frame_start)
    );

endmodule

/* include/readout_tb_tasks.svh */
`ifndef READOUT_TB_TASKS_SVH
`define READOUT_TB_TASKS_SVH

// ----------------------------------------
// galois lfsr
// ----------------------------------------

// x^16 + x^14 + x^13 + x^11 + 1, right shifting
// one step per bit taken, the bit is the new lsb
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 16'hB400;
    end
    return nxt;
endfunction

// ----------------------------------------
// compare tasks, one per result kind
// ----------------------------------------

// pixel words on the output bus
task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
endtask

// one-hot bank vectors
task automatic check_bank(input string name, input bank_onehot_t got, input bank_onehot_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
endtask

// pulse, beat and line counts
task automatic check_count(input string name, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
        err_cnt++;
        $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
endtask

// single-bit flags
task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
endtask

`endif

/* dv/readout_mux_tb.sv */
`timescale 1ns/100ps

module readout_mux_tb
    import readout_geom_pkg::*;
();

    // header words plus a word pair per bank
    localparam int FRAME_WORDS = 5 + 2 * NUM_BANKS;
    // first data_valid to frame_start
    localparam int START_LAG   = 9;
    // idle cycles after a line and after a frame
    localparam int LINE_GAP    = 8;
    localparam int FRAME_GAP   = 24;

    logic         eim_clk = 1'b0;
    logic         eim_rst;
    logic         read_index;
    logic         aed_read_index;
    logic         line_start;
    logic         csi_done;
    line_cnt_t    image_height;
    logic         valid_read_mem;
    logic         axis_tready;
    pixel_t       bank_a [NUM_BANKS];
    pixel_t       bank_b [NUM_BANKS];
    logic         data_valid;
    logic         axis_tlast;
    pixel_t       data_out_a;
    pixel_t       data_out_b;
    logic         frame_start;
    logic         frame_reset;
    bank_onehot_t bank_read_req;

    pixel_t       pat_mem [256];
    int           err_cnt;
    int           check_cnt;
    int           num_frames;
    int           cycle;
    int           cycle_limit;
    logic [15:0]  lfsr;
    logic         exp_csi;
    // monitor counters kept over the whole run
    int           line_beats;
    int           line_reqs;
    int           lines_seen;
    int           resets_seen;
    int           starts_seen;
    int           first_dv_cycle;
    int           frame_begin_cycle;

    `include "readout_tb_tasks.svh"

    readout_mux_top u_readout_mux_top (
        .eim_clk        (eim_clk),
        .eim_rst        (eim_rst),
        .read_index     (read_index),
        .aed_read_index (aed_read_index),
        .line_start     (line_start),
        .csi_done       (csi_done),
        .image_height   (image_height),
        .valid_read_mem (valid_read_mem),
        .axis_tready    (axis_tready),
        .bank_data_a    (bank_a),
        .bank_data_b    (bank_b),
        .data_valid     (data_valid),
        .axis_tlast     (axis_tlast),
        .data_out_a     (data_out_a),
        .data_out_b     (data_out_b),
        .frame_start    (frame_start),
        .frame_reset    (frame_reset),
        .bank_read_req  (bank_read_req)
    );

    // 8 ns period
    always #4 eim_clk = ~eim_clk;

    // ready takes one lfsr bit per cycle
    always @(posedge eim_clk) begin
        #1;
        lfsr        = lfsr_next(lfsr);
        axis_tready = lfsr[0];
    end

    // ----------------------------------------
    // run control
    // ----------------------------------------

    task automatic end_run;
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // drive slot just after the rising edge
    task automatic step_cycle;
        @(posedge eim_clk);
        #1;
    endtask

    task automatic run_frame(input int f);
        int base;
        int height;
        int resets0;
        int starts0;
        int lines0;
        base   = 1 + f * FRAME_WORDS;
        height = int'(pat_mem[base]);
        step_cycle();
        image_height   = line_cnt_t'(height);
        csi_done       = pat_mem[base+1][0];
        aed_read_index = pat_mem[base+2][0];
        exp_csi        = pat_mem[base+1][0];
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_a[b] = pat_mem[base+5+2*b];
            bank_b[b] = pat_mem[base+6+2*b];
        end
        resets0           = resets_seen;
        starts0           = starts_seen;
        lines0            = lines_seen;
        frame_begin_cycle = cycle;
        read_index        = 1'b1;
        // restart, trigger and frame reset go by
        repeat (10) step_cycle();
        for (int l = 0; l < height; l++) begin
            line_start = 1'b1;
            step_cycle();
            line_start = 1'b0;
            // last beat of the line seen on the output
            wait (lines_seen >= lines0 + l + 1);
            repeat (LINE_GAP) step_cycle();
        end
        // vsync hold runs out
        repeat (FRAME_GAP) step_cycle();
        read_index     = 1'b0;
        aed_read_index = 1'b0;
        repeat (4) step_cycle();
        check_count("frame_reset pulses", resets_seen - resets0, int'(pat_mem[base+3]));
        check_count("frame_start pulses", starts_seen - starts0, int'(pat_mem[base+4]));
        check_count("lines per frame", lines_seen - lines0, height);
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial begin
        int total_beats;
        eim_rst           = 1'b0;
        read_index        = 1'b0;
        aed_read_index    = 1'b0;
        line_start        = 1'b0;
        csi_done          = 1'b0;
        image_height      = '0;
        valid_read_mem    = 1'b1;
        axis_tready       = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_a[b] = '0;
            bank_b[b] = '0;
        end
        lfsr              = 16'd38;
        exp_csi           = 1'b0;
        err_cnt           = 0;
        check_cnt         = 0;
        cycle             = 0;
        line_beats        = 0;
        line_reqs         = 0;
        lines_seen        = 0;
        resets_seen       = 0;
        starts_seen       = 0;
        first_dv_cycle    = -1;
        frame_begin_cycle = 0;
        $readmemh("dv/readout_patterns.txt", pat_mem);
        num_frames = int'(pat_mem[0]);
        total_beats = 0;
        for (int f = 0; f < num_frames; f++) begin
            total_beats += int'(pat_mem[1 + f * FRAME_WORDS]) * LINE_BEATS;
        end
        // four cycles a beat plus setup and gaps per frame
        cycle_limit = total_beats * 4 + num_frames * 200 + 100;
        repeat (3) @(posedge eim_clk);
        #1;
        eim_rst = 1'b1;
        // quiet outputs out of reset
        @(negedge eim_clk);
        check_flag("data_valid", data_valid, 1'b0);
        check_flag("axis_tlast", axis_tlast, 1'b0);
        check_flag("frame_start", frame_start, 1'b0);
        check_flag("frame_reset", frame_reset, 1'b0);
        check_bank("bank_read_req", bank_read_req, '0);
        for (int f = 0; f < num_frames; f++) begin
            run_frame(f);
        end
        end_run();
    end

    // ----------------------------------------
    // monitor and scoreboard at mid cycle
    // ----------------------------------------

    always @(negedge eim_clk) begin
        int bidx;
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            err_cnt++;
            end_run();
        end else if (eim_rst) begin
            // requests walk the banks 128 at a time and only with csi done
            if (bank_read_req != '0) begin
                check_bank("bank_read_req", bank_read_req,
                           exp_csi ? bank_onehot_t'(1) << (line_reqs / PIXELS_PER_BANK) : '0);
                line_reqs++;
            end
            if (data_valid) begin
                if (first_dv_cycle < frame_begin_cycle) begin
                    first_dv_cycle = cycle;
                end
                bidx = line_beats / PIXELS_PER_BANK;
                if (bidx >= NUM_BANKS) begin
                    bidx = NUM_BANKS - 1;
                end
                check_pixel("data_out_a", data_out_a, bank_a[bidx]);
                check_pixel("data_out_b", data_out_b, bank_b[bidx]);
                check_flag("axis_tlast", axis_tlast, line_beats == LINE_BEATS - 1);
                line_beats++;
                if (axis_tlast) begin
                    check_count("requests per line", line_reqs, exp_csi ? LINE_BEATS : 0);
                    line_beats = 0;
                    line_reqs  = 0;
                    lines_seen++;
                end
            end else begin
                check_flag("axis_tlast", axis_tlast, 1'b0);
            end
            if (frame_reset) begin
                resets_seen++;
            end
            if (frame_start) begin
                starts_seen++;
                check_count("frame_start lag", cycle - first_dv_cycle, START_LAG);
            end
        end
    end

endmodule

/* dv/readout_patterns.txt */
// word 0 frame count; per frame: height csi_done aed exp_frame_resets exp_frame_starts
// then bank 0..11 word pairs (data_a data_b), four pairs per line
4
2 1 0 1 1
10A5C3 103C5A 11A5C3 113C5A 12A5C3 123C5A 13A5C3 133C5A
14A5C3 143C5A 15A5C3 153C5A 16A5C3 163C5A 17A5C3 173C5A
18A5C3 183C5A 19A5C3 193C5A 1AA5C3 1A3C5A 1BA5C3 1B3C5A
1 0 0 1 1
20F00D 200FF1 21F00D 210FF1 22F00D 220FF1 23F00D 230FF1
24F00D 240FF1 25F00D 250FF1 26F00D 260FF1 27F00D 270FF1
28F00D 280FF1 29F00D 290FF1 2AF00D 2A0FF1 2BF00D 2B0FF1
1 1 1 0 0
305A5A 30A5A5 315A5A 31A5A5 325A5A 32A5A5 335A5A 33A5A5
345A5A 34A5A5 355A5A 35A5A5 365A5A 36A5A5 375A5A 37A5A5
385A5A 38A5A5 395A5A 39A5A5 3A5A5A 3AA5A5 3B5A5A 3BA5A5
2 1 0 1 1
40BEEF 40CAFE 41BEEF 41CAFE 42BEEF 42CAFE 43BEEF 43CAFE
44BEEF 44CAFE 45BEEF 45CAFE 46BEEF 46CAFE 47BEEF 47CAFE
48BEEF 48CAFE 49BEEF 49CAFE 4ABEEF 4ACAFE 4BBEEF 4BCAFE

/* filelist.f */
+incdir+include
source/readout_geom_pkg.sv
source/readout_ctrl_pkg.sv
source/frame_sync_gen.sv
source/line_sync_gen.sv
source/pixel_counter.sv
source/bank_sequencer.sv
source/pixel_output_stage.sv
source/readout_mux_top.sv
dv/readout_mux_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the readout testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f filelist.f \
    --top-module readout_mux_tb -o readout_sim
./obj_dir/readout_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1
